/* layer_pkg.sv */
// Shared widths, field positions and hand-off structs, imported by every renderer module
package layer_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths that carry a meaning
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [8:0]  line_idx_t;
    typedef logic [11:0] scroll_t;
    // Base address in units of 128 words
    typedef logic [7:0]  base_t;
    typedef logic [14:0] bus_addr_t;
    typedef logic [31:0] bus_word_t;
    typedef logic [9:0]  lb_idx_t;
    typedef logic [7:0]  color_t;
    typedef logic [9:0]  tile_idx_t;
    // Map size is 32 tiles shifted left by this code
    typedef logic [1:0]  map_size_t;
    typedef logic [3:0]  nibble_t;

    ////////////////////////////////////////////////////////////////////////////
    // Layout constants
    ////////////////////////////////////////////////////////////////////////////

    // Last line buffer index written is LINE_PIXELS - 1
    localparam int LINE_PIXELS = 320;
    localparam int TILE_PIXELS = 8;
    localparam int BASE_SHIFT  = 7;

    // Map entry fields, tile number sits in bits 9:0
    localparam int MAP_FLIP_H_BIT = 10;
    localparam int MAP_FLIP_V_BIT = 11;
    localparam int MAP_PAL_LSB    = 12;

    ////////////////////////////////////////////////////////////////////////////
    // Structs
    ////////////////////////////////////////////////////////////////////////////

    // Layer registers, held stable for a whole line
    typedef struct packed {
        logic      bpp8;
        map_size_t map_width;
        map_size_t map_height;
        base_t     map_base;
        base_t     tile_base;
        scroll_t   hscroll;
        scroll_t   vscroll;
    } layer_cfg_t;

    // Fetched tile word plus the per-tile attributes the unpacker needs
    typedef struct packed {
        bus_word_t data;
        logic      hflip;
        nibble_t   pal_offset;
        logic      bpp8;
    } tile_word_t;

endpackage

/* map_tile_fetcher.sv */
// Walks the tiles of a line, reads map entries and tile words over the bus, hands words on
`timescale 1ns/1ns

module map_tile_fetcher
    import layer_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       line_start,
    input  line_idx_t  line_idx,
    input  layer_cfg_t cfg,
    input  bus_word_t  bus_rddata,
    input  logic       bus_ack,
    input  logic       word_ready,
    output bus_addr_t  bus_addr,
    output logic       bus_strobe,
    output logic       word_valid,
    output tile_word_t word
);

    typedef enum logic [2:0] {
        FETCH_IDLE,
        FETCH_MAP_REQ,
        FETCH_MAP_WAIT,
        FETCH_TILE_REQ,
        FETCH_TILE_WAIT,
        FETCH_HAND
    } fetch_state_e;

    fetch_state_e state;
    logic         req;
    logic [7:0]   tile_cnt;
    logic         half;
    bus_word_t    map_data;

    scroll_t      scrolled_line;
    logic [7:0]   row_mask;
    logic [7:0]   col_mask;
    logic [7:0]   map_row;
    logic [7:0]   map_col;
    logic [15:0]  map_idx;
    logic [15:0]  entry;
    tile_idx_t    tile;
    logic         hflip;
    logic         vflip;
    logic [2:0]   tile_row;
    bus_addr_t    tile_offset;
    bus_addr_t    map_addr;
    bus_addr_t    tile_addr;

    ////////////////////////////////////////////////////////////////////////////
    // Address generation
    ////////////////////////////////////////////////////////////////////////////

    assign scrolled_line = {3'b000, line_idx} + cfg.vscroll;

    // Power-of-two map sizes, so wrap is a mask
    assign row_mask = 8'hff >> (2'd3 - cfg.map_height);
    assign col_mask = 8'hff >> (2'd3 - cfg.map_width);
    assign map_row  = scrolled_line[10:3] & row_mask;
    assign map_col  = (tile_cnt + cfg.hscroll[10:3]) & col_mask;
    assign map_idx  = ({8'h00, map_row} << (4'd5 + cfg.map_width)) | {8'h00, map_col};
    assign map_addr = (bus_addr_t'(cfg.map_base) << BASE_SHIFT) + map_idx[15:1];

    // Two 16-bit entries per map word
    assign entry    = map_idx[0] ? map_data[31:16] : map_data[15:0];
    assign tile     = entry[9:0];
    assign hflip    = entry[MAP_FLIP_H_BIT];
    assign vflip    = entry[MAP_FLIP_V_BIT];
    assign tile_row = vflip ? ~scrolled_line[2:0] : scrolled_line[2:0];

    // 8bpp rows span two words, taken in reverse order when flipped
    assign tile_offset = cfg.bpp8 ? {1'b0, tile, tile_row, half ^ hflip}
                                  : {2'b00, tile, tile_row};
    assign tile_addr   = (bus_addr_t'(cfg.tile_base) << BASE_SHIFT) + tile_offset;

    assign bus_strobe = req && !bus_ack;

    ////////////////////////////////////////////////////////////////////////////
    // Fetch FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= FETCH_IDLE;
            req        <= 1'b0;
            tile_cnt   <= '0;
            half       <= 1'b0;
            word_valid <= 1'b0;
        end else if (line_start) begin
            state      <= FETCH_MAP_REQ;
            req        <= 1'b0;
            tile_cnt   <= '0;
            half       <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            case (state)
                FETCH_MAP_REQ: begin
                    req   <= 1'b1;
                    state <= FETCH_MAP_WAIT;
                end
                FETCH_MAP_WAIT: begin
                    if (bus_ack) begin
                        req   <= 1'b0;
                        state <= FETCH_TILE_REQ;
                    end
                end
                FETCH_TILE_REQ: begin
                    req   <= 1'b1;
                    state <= FETCH_TILE_WAIT;
                end
                FETCH_TILE_WAIT: begin
                    if (bus_ack) begin
                        req        <= 1'b0;
                        word_valid <= 1'b1;
                        state      <= FETCH_HAND;
                    end
                end
                FETCH_HAND: begin
                    if (word_ready) begin
                        word_valid <= 1'b0;
                        if (cfg.bpp8 && !half) begin
                            half  <= 1'b1;
                            state <= FETCH_TILE_REQ;
                        end else begin
                            half     <= 1'b0;
                            tile_cnt <= tile_cnt + 8'd1;
                            // Odd column now, so the next entry lives in a new map word
                            state    <= map_col[0] ? FETCH_MAP_REQ : FETCH_TILE_REQ;
                        end
                    end
                end
                default: begin
                    state <= FETCH_IDLE;
                end
            endcase
        end
    end

    // Address, map word and tile word capture
    always_ff @(posedge clk) begin
        if (state == FETCH_MAP_REQ) begin
            bus_addr <= map_addr;
        end
        if (state == FETCH_TILE_REQ) begin
            bus_addr <= tile_addr;
        end
        if (state == FETCH_MAP_WAIT && bus_ack) begin
            map_data <= bus_rddata;
        end
        if (state == FETCH_TILE_WAIT && bus_ack) begin
            word.data       <= bus_rddata;
            word.hflip      <= hflip;
            word.pal_offset <= entry[MAP_PAL_LSB +: 4];
            word.bpp8       <= cfg.bpp8;
        end
    end

endmodule

/* pixel_unpacker.sv */
// Splits each tile word into palette colors, one per cycle, applying flip and palette offset
`timescale 1ns/1ns

module pixel_unpacker
    import layer_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       line_start,
    input  logic       word_valid,
    input  tile_word_t word,
    input  logic       pix_ready,
    output logic       word_ready,
    output logic       pix_valid,
    output color_t     pix
);

    tile_word_t cur;
    logic       loaded;
    logic [2:0] cnt;
    logic [2:0] last_idx;
    logic [2:0] pos;
    logic       last;
    logic       advance;
    logic [3:0] nib;
    color_t     raw;
    color_t     color;

    // 8 pixels per word at 4bpp, 4 at 8bpp
    assign last_idx = cur.bpp8 ? 3'(TILE_PIXELS / 2 - 1) : 3'(TILE_PIXELS - 1);
    assign pos      = cur.hflip ? last_idx - cnt : cnt;
    assign last     = (cnt == last_idx);

    // Output slot free when empty or being taken this cycle
    assign advance    = !pix_valid || pix_ready;
    assign word_ready = !loaded || (advance && last);

    ////////////////////////////////////////////////////////////////////////////
    // Pixel select and palette offset
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // Even positions take the high nibble
        nib = cur.data[{pos[2:1], ~pos[0], 2'b00} +: 4];
        if (cur.bpp8) begin
            raw = cur.data[{pos[1:0], 3'b000} +: 8];
        end else begin
            raw = {4'h0, nib};
        end
        if (raw[7:4] == 4'h0 && raw[3:0] != 4'h0) begin
            color = {cur.pal_offset, raw[3:0]};
        end else begin
            color = raw;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pixel counter and output register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            loaded    <= 1'b0;
            cnt       <= '0;
            pix_valid <= 1'b0;
        end else if (line_start) begin
            loaded    <= 1'b0;
            cnt       <= '0;
            pix_valid <= 1'b0;
        end else begin
            if (advance) begin
                pix_valid <= loaded;
                if (loaded) begin
                    if (last) begin
                        cnt    <= '0;
                        loaded <= 1'b0;
                    end else begin
                        cnt <= cnt + 3'd1;
                    end
                end
            end
            // A new word may land in the same cycle as the last pixel
            if (word_valid && word_ready) begin
                loaded <= 1'b1;
                cnt    <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance && loaded) begin
            pix <= color;
        end
        if (word_valid && word_ready) begin
            cur <= word;
        end
    end

endmodule

/* line_writer.sv */
// Writes accepted pixels to the line buffer from the sub-tile scroll start up to the line end
`timescale 1ns/1ns

module line_writer
    import layer_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    line_start,
    input  scroll_t hscroll,
    input  logic    pix_valid,
    input  color_t  pix,
    output logic    pix_ready,
    output lb_idx_t linebuf_idx,
    output color_t  linebuf_data,
    output logic    linebuf_wren
);

    lb_idx_t idx;
    logic    done;
    logic    transfer;

    // Idle until the first line starts
    assign pix_ready = !done;
    assign transfer  = pix_valid && pix_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idx          <= '0;
            done         <= 1'b1;
            linebuf_wren <= 1'b0;
        end else if (line_start) begin
            // Start left of index 0 by the fine scroll, wrapping to the top of the buffer
            idx          <= lb_idx_t'(0) - lb_idx_t'(hscroll[2:0]);
            done         <= 1'b0;
            linebuf_wren <= 1'b0;
        end else begin
            linebuf_wren <= transfer;
            if (transfer) begin
                idx <= idx + lb_idx_t'(1);
                if (idx == lb_idx_t'(LINE_PIXELS - 1)) begin
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (transfer) begin
            linebuf_idx  <= idx;
            linebuf_data <= pix;
        end
    end

endmodule

/* layer_renderer.sv */
// Tile layer line renderer top, chains fetcher, unpacker and line buffer writer
`timescale 1ns/1ns

module layer_renderer
    import layer_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // Line control and layer registers
    input  line_idx_t  line_idx,
    input  logic       line_start,
    input  layer_cfg_t cfg,

    // Video memory bus
    output bus_addr_t  bus_addr,
    output logic       bus_strobe,
    input  bus_word_t  bus_rddata,
    input  logic       bus_ack,

    // Line buffer write port
    output lb_idx_t    linebuf_idx,
    output color_t     linebuf_data,
    output logic       linebuf_wren
);

    // Fetcher to unpacker
    logic       word_valid;
    logic       word_ready;
    tile_word_t word;

    // Unpacker to writer
    logic       pix_valid;
    logic       pix_ready;
    color_t     pix;

    map_tile_fetcher fetch0 (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .line_idx   (line_idx),
        .cfg        (cfg),
        .bus_rddata (bus_rddata),
        .bus_ack    (bus_ack),
        .word_ready (word_ready),
        .bus_addr   (bus_addr),
        .bus_strobe (bus_strobe),
        .word_valid (word_valid),
        .word       (word)
    );

    pixel_unpacker unpack0 (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .word_valid (word_valid),
        .word       (word),
        .pix_ready  (pix_ready),
        .word_ready (word_ready),
        .pix_valid  (pix_valid),
        .pix        (pix)
    );

    line_writer write0 (
        .clk          (clk),
        .rst          (rst),
        .line_start   (line_start),
        .hscroll      (cfg.hscroll),
        .pix_valid    (pix_valid),
        .pix          (pix),
        .pix_ready    (pix_ready),
        .linebuf_idx  (linebuf_idx),
        .linebuf_data (linebuf_data),
        .linebuf_wren (linebuf_wren)
    );

endmodule

/* layer_renderer_sva.sv */
// Bus and line buffer port assertions bound into the renderer top by the testbench
`timescale 1ns/1ns

module layer_renderer_sva
    import layer_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input bus_addr_t bus_addr,
    input logic      bus_strobe,
    input lb_idx_t   linebuf_idx,
    input logic      linebuf_wren
);

    // Address held from the strobe until the ack
    addr_stable: assert property (@(posedge clk) disable iff (rst)
        bus_strobe |=> $stable(bus_addr))
        else $error("bus_addr changed while the strobe waited for an ack");

    // Only visible indices or the fine scroll lead-in below the top of the buffer
    idx_range: assert property (@(posedge clk) disable iff (rst)
        linebuf_wren |-> (linebuf_idx < lb_idx_t'(LINE_PIXELS)
                          || linebuf_idx >= lb_idx_t'(1024 - TILE_PIXELS + 1)))
        else $error("line buffer write index %0d out of range", linebuf_idx);

    // Nothing written after the last visible index of a line
    line_end: assert property (@(posedge clk) disable iff (rst)
        linebuf_wren && linebuf_idx == lb_idx_t'(LINE_PIXELS - 1) |=> !linebuf_wren)
        else $error("line buffer write followed index %0d", LINE_PIXELS - 1);

endmodule

/* tb_clock_gen.sv */
// Testbench clock and reset source, 8 ns clock with reset held high for the first 8 cycles
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* tb_layer_renderer.sv */
// Testbench top for the tile layer renderer that runs directed line tests against a reference model
`timescale 1ns/1ns

module tb_layer_renderer
    import layer_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 20000;
    localparam int MEM_WORDS      = 32768;

    logic       clk;
    logic       rst;
    line_idx_t  line_idx;
    logic       line_start;
    layer_cfg_t cfg;
    bus_addr_t  bus_addr;
    logic       bus_strobe;
    bus_word_t  bus_rddata = '0;
    logic       bus_ack = 1'b0;
    lb_idx_t    linebuf_idx;
    color_t     linebuf_data;
    logic       linebuf_wren;

    bus_word_t  mem [MEM_WORDS];
    logic       mem_pending = 1'b0;
    logic [1:0] mem_wait = '0;

    // Expected writes of the current line in write order
    lb_idx_t    exp_idx[$];
    color_t     exp_data[$];
    int         writes_seen = 0;
    int         first_idx_seen = -1;
    int         checks = 0;
    int         errors = 0;
    int         cycles = 0;

    tb_clock_gen clk_gen0 (
        .clk (clk),
        .rst (rst)
    );

    layer_renderer dut0 (
        .clk          (clk),
        .rst          (rst),
        .line_idx     (line_idx),
        .line_start   (line_start),
        .cfg          (cfg),
        .bus_addr     (bus_addr),
        .bus_strobe   (bus_strobe),
        .bus_rddata   (bus_rddata),
        .bus_ack      (bus_ack),
        .linebuf_idx  (linebuf_idx),
        .linebuf_data (linebuf_data),
        .linebuf_wren (linebuf_wren)
    );

    bind layer_renderer layer_renderer_sva sva0 (
        .clk          (clk),
        .rst          (rst),
        .bus_addr     (bus_addr),
        .bus_strobe   (bus_strobe),
        .linebuf_idx  (linebuf_idx),
        .linebuf_wren (linebuf_wren)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Video memory model and line buffer monitor
    ////////////////////////////////////////////////////////////////////////////

    // Acks each strobe after 1 to 3 cycles
    always @(posedge clk) begin
        if (rst) begin
            bus_ack     <= 1'b0;
            mem_pending <= 1'b0;
        end else if (bus_ack) begin
            bus_ack <= 1'b0;
        end else if (mem_pending) begin
            if (!bus_strobe) begin
                // Request withdrawn by a line restart
                mem_pending <= 1'b0;
            end else if (mem_wait == 2'd0) begin
                bus_ack     <= 1'b1;
                bus_rddata  <= mem[bus_addr];
                mem_pending <= 1'b0;
            end else begin
                mem_wait <= mem_wait - 2'd1;
            end
        end else if (bus_strobe) begin
            mem_pending <= 1'b1;
            mem_wait    <= 2'($urandom_range(2, 0));
        end
    end

    always @(negedge clk) begin
        if (!rst && linebuf_wren === 1'b1) begin
            checks++;
            if (exp_idx.size() == 0) begin
                errors++;
                $display("Line buffer write to index %0d where none was expected, at %0t",
                         linebuf_idx, $time);
            end else begin
                if (linebuf_idx !== exp_idx[0] || linebuf_data !== exp_data[0]) begin
                    errors++;
                    $display("FAILED %0t: write %0d index %0d data %02h, expected %0d data %02h",
                             $time, writes_seen, linebuf_idx, linebuf_data, exp_idx[0],
                             exp_data[0]);
                end
                void'(exp_idx.pop_front());
                void'(exp_data.pop_front());
            end
            if (writes_seen == 0) begin
                first_idx_seen = int'(linebuf_idx);
            end
            writes_seen++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and line control
    ////////////////////////////////////////////////////////////////////////////

    task automatic build_expected(input layer_cfg_t c, input line_idx_t ln);
        int          fine;
        int          s;
        int          width;
        int          row;
        int          j;
        int          k;
        int          col;
        int          midx;
        int          tile;
        int          r;
        int          half;
        int          p;
        int          taddr;
        logic [15:0] entry;
        bus_word_t   map_word;
        bus_word_t   tile_word;
        color_t      raw;
        exp_idx.delete();
        exp_data.delete();
        fine  = int'(c.hscroll[2:0]);
        s     = (int'(ln) + int'(c.vscroll)) % 4096;
        width = 32 << c.map_width;
        row   = (s / 8) % (32 << c.map_height);
        for (j = 0; j < LINE_PIXELS + fine; j++) begin
            k        = j % 8;
            col      = (j / 8 + int'(c.hscroll[10:3])) % width;
            midx     = row * width + col;
            map_word = mem[(int'(c.map_base) * 128 + midx / 2) % MEM_WORDS];
            entry    = (midx % 2 == 1) ? map_word[31:16] : map_word[15:0];
            tile     = int'(entry[9:0]);
            r        = entry[11] ? 7 - s % 8 : s % 8;
            if (c.bpp8) begin
                // Two words per row with the second half first when flipped
                half      = entry[10] ? 1 - k / 4 : k / 4;
                p         = entry[10] ? 3 - k % 4 : k % 4;
                taddr     = int'(c.tile_base) * 128 + tile * 16 + 2 * r + half;
                tile_word = mem[taddr % MEM_WORDS];
                raw       = tile_word[p * 8 +: 8];
            end else begin
                p         = entry[10] ? 7 - k : k;
                taddr     = int'(c.tile_base) * 128 + tile * 8 + r;
                tile_word = mem[taddr % MEM_WORDS];
                raw       = {4'h0, tile_word[(p / 2) * 8 + (p % 2 == 0 ? 4 : 0) +: 4]};
            end
            if (raw >= 8'd1 && raw <= 8'd15) begin
                raw = {entry[15:12], raw[3:0]};
            end
            exp_idx.push_back(lb_idx_t'((1024 - fine + j) % 1024));
            exp_data.push_back(raw);
        end
    endtask

    function automatic layer_cfg_t make_cfg(input logic bpp8, input map_size_t mw,
                                            input map_size_t mh, input logic scrolled);
        layer_cfg_t c;
        c.bpp8       = bpp8;
        c.map_width  = mw;
        c.map_height = mh;
        c.map_base   = base_t'($urandom());
        c.tile_base  = base_t'($urandom());
        c.hscroll    = scrolled ? scroll_t'($urandom()) : '0;
        c.vscroll    = scrolled ? scroll_t'($urandom()) : '0;
        return c;
    endfunction

    task automatic start_line(input layer_cfg_t c, input line_idx_t ln);
        @(posedge clk);
        cfg        <= c;
        line_idx   <= ln;
        line_start <= 1'b1;
        @(posedge clk);
        line_start <= 1'b0;
        build_expected(c, ln);
        writes_seen    = 0;
        first_idx_seen = -1;
    endtask

    task automatic wait_writes(input int count);
        while (writes_seen < count) begin
            @(posedge clk);
        end
    endtask

    task automatic finish_line(input layer_cfg_t c, input string name);
        int fine;
        fine = int'(c.hscroll[2:0]);
        while (exp_idx.size() != 0) begin
            @(posedge clk);
        end
        // Room for a stray write or a runaway fetch to show
        repeat (40) @(posedge clk);
        @(negedge clk);
        checks += 3;
        if (writes_seen != LINE_PIXELS + fine) begin
            errors++;
            $display("FAILED %0t: %s gave %0d writes, expected %0d",
                     $time, name, writes_seen, LINE_PIXELS + fine);
        end
        if (first_idx_seen != (1024 - fine) % 1024) begin
            errors++;
            $display("FAILED %0t: %s started at index %0d, expected %0d",
                     $time, name, first_idx_seen, (1024 - fine) % 1024);
        end
        if (bus_strobe !== 1'b0) begin
            errors++;
            $display("FAILED %0t: %s left the bus strobe high after the line end", $time, name);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_reset_idle();
        int n;
        for (n = 0; n < 24; n++) begin
            @(negedge clk);
            checks++;
            if (bus_strobe !== 1'b0 || linebuf_wren !== 1'b0) begin
                errors++;
                $display("FAILED %0t: strobe %b write enable %b before the first line start",
                         $time, bus_strobe, linebuf_wren);
            end
        end
    endtask

    task automatic test_unscrolled(input logic bpp8);
        layer_cfg_t c;
        int         i;
        for (i = 0; i < 2; i++) begin
            c = make_cfg(bpp8, map_size_t'(i), map_size_t'(i + 1), 1'b0);
            start_line(c, (i == 0) ? line_idx_t'(0) : line_idx_t'($urandom_range(479, 1)));
            finish_line(c, bpp8 ? "8bpp line" : "4bpp line");
        end
    endtask

    task automatic test_scrolled();
        layer_cfg_t c;
        int         i;
        for (i = 0; i < 6; i++) begin
            c = make_cfg(1'($urandom()), map_size_t'(i % 4), map_size_t'((3 * i + 1) % 4), 1'b1);
            // Nonzero fine scroll gives lead-in writes above index 1016
            c.hscroll[2:0] = 3'(i % 7 + 1);
            start_line(c, line_idx_t'($urandom_range(479, 0)));
            finish_line(c, "scrolled line");
        end
    endtask

    task automatic test_restart();
        layer_cfg_t c;
        c = make_cfg(1'b1, map_size_t'(2), map_size_t'(1), 1'b1);
        start_line(c, line_idx_t'($urandom_range(479, 0)));
        wait_writes(150);
        c = make_cfg(1'b0, map_size_t'(3), map_size_t'(3), 1'b1);
        start_line(c, line_idx_t'($urandom_range(479, 0)));
        finish_line(c, "restarted line");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Run control
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped by the timeout after %0d cycles", cycles);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'hc7c3b26b));
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = $urandom();
        end
        line_idx   = '0;
        line_start = 1'b0;
        cfg        = '0;
        @(negedge rst);
        check_reset_idle();
        test_unscrolled(1'b0);
        test_unscrolled(1'b1);
        test_scrolled();
        test_restart();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
layer_pkg.sv
map_tile_fetcher.sv
pixel_unpacker.sv
line_writer.sv
layer_renderer.sv
layer_renderer_sva.sv
tb_clock_gen.sv
tb_layer_renderer.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_layer_renderer
FILELIST  = build.f
OBJDIR    = obj_dir
LOG       = sim.log

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG) || ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
